// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mtl_memory_adapter
FILELIST  ?= sources.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Regression failed" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/address_decoder.sv ====
module address_decoder (
    input  logic [15:0]                  i_addr,
    input  logic                         i_prog_mode,    // High while the USB bridge owns flash
    output mtl_adapter_pkg::mem_region_t o_region,
    output logic                         o_sram_sel,
    output logic                         o_rom_sel,
    output logic                         o_exp_mem_sel,
    output logic                         o_exp_io_sel
);
    import mtl_adapter_pkg::*;

    always_comb begin
        if (i_addr <= SRAM_LAST) begin
            o_region = REGION_SRAM;                           // Lowest 4 KB
        end else if (i_addr >= ROM_FIRST) begin
            o_region = REGION_ROM;                            // Top 4 KB
        end else if ((i_addr >= EXP_MEM_FIRST) && (i_addr <= EXP_MEM_LAST)) begin
            o_region = REGION_EXP_MEM;
        end else if ((i_addr >= EXP_IO_FIRST) && (i_addr <= EXP_IO_LAST)) begin
            o_region = REGION_EXP_IO;
        end else begin
            o_region = REGION_NONE;                           // 0x8000 gap and 0xC000 to 0xEFFF
        end
    end

    assign o_sram_sel    = (o_region == REGION_SRAM);
    assign o_rom_sel     = (o_region == REGION_ROM) && !i_prog_mode;  // CPU kept off the flash
    assign o_exp_mem_sel = (o_region == REGION_EXP_MEM);
    assign o_exp_io_sel  = (o_region == REGION_EXP_IO);

    // Overlapping windows in the map would hide behind the priority chain above
    always_comb begin
        map_disjoint: assert ($onehot0({i_addr <= SRAM_LAST,
                                        i_addr >= ROM_FIRST,
                                        (i_addr >= EXP_MEM_FIRST) && (i_addr <= EXP_MEM_LAST),
                                        (i_addr >= EXP_IO_FIRST) && (i_addr <= EXP_IO_LAST)}));
    end

endmodule

// ==== source/e_clk_delay.sv ====
module e_clk_delay #(
    parameter int E_LONG_DELAY  = 3,
    parameter int E_SHORT_DELAY = 1
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_e,        // E clock straight from the 6809
    output logic o_e_long,   // Late qualifier for SRAM and flash start
    output logic o_e_short   // Early qualifier for the buffer enable
);

    logic [1:0]              e_sync;  // Two flop synchronizer
    logic [E_LONG_DELAY-1:0] e_pipe;  // Bit k is sync E delayed k+1 cycles

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            e_sync <= '0;
            e_pipe <= '0;
        end else begin
            e_sync <= {e_sync[0], i_e};                         // E is asynchronous here
            e_pipe <= {e_pipe[E_LONG_DELAY-2:0], e_sync[1]};    // Shift toward the long tap
        end
    end

    assign o_e_long  = e_pipe[E_LONG_DELAY-1];   // Both edges delayed equally
    assign o_e_short = e_pipe[E_SHORT_DELAY-1];

    // The short tap must sit inside the pipe and ahead of the long tap
    delay_order: assert property (@(posedge i_clk) disable iff (i_rst)
        (E_SHORT_DELAY >= 1) && (E_SHORT_DELAY < E_LONG_DELAY));

endmodule

// ==== source/mtl_adapter_pkg.sv ====
package mtl_adapter_pkg;

    // Regions of the 6809 address space as seen by the memory board
    typedef enum logic [2:0] {
        REGION_NONE    = 3'd0,  // Unmapped hole
        REGION_SRAM    = 3'd1,  // Onboard 4 KB SRAM
        REGION_EXP_MEM = 3'd2,  // Memory expansion connector
        REGION_EXP_IO  = 3'd3,  // I/O expansion connector
        REGION_ROM     = 3'd4   // Monitor ROM held in SPI flash
    } mem_region_t;

    // SRAM starts at 0x0000 so only its top is needed
    localparam logic [15:0] SRAM_LAST     = 16'h0FFF;

    localparam logic [15:0] EXP_MEM_FIRST = 16'h1000;  // Expansion memory window
    localparam logic [15:0] EXP_MEM_LAST  = 16'h7FFF;

    localparam logic [15:0] EXP_IO_FIRST  = 16'hA000;  // Expansion I/O window
    localparam logic [15:0] EXP_IO_LAST   = 16'hBFFF;

    // ROM runs to the top of memory and holds the reset vectors
    localparam logic [15:0] ROM_FIRST     = 16'hF000;

    localparam logic [7:0]  FLASH_READ_CMD = 8'h03;  // Plain READ with no dummy cycles
    localparam int          FLASH_ADDR_W   = 24;     // Three address bytes

endpackage

// ==== source/mtl_memory_adapter.sv ====
module mtl_memory_adapter #(
    parameter int                                   E_LONG_DELAY  = 3,
    parameter int                                   E_SHORT_DELAY = 1,
    parameter int                                   SPI_CLK_DIV   = 2,
    parameter logic [mtl_adapter_pkg::FLASH_ADDR_W-1:0] FLASH_BASE    = '0
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [15:0] i_addr,
    input  logic        i_rw,
    input  logic        i_e,
    input  logic [7:0]  i_data,       // Write data goes straight to the SRAM pins
    output logic [7:0]  o_data,
    output logic        o_data_oe,    // Pad driver enable in the board wrapper
    output logic        o_mrdy,
    output logic        o_dben_n,     // Data bus buffer enable
    output logic        o_sram_ce_n,
    output logic        o_sram_ce2,
    output logic        o_sram_we_n,
    output logic        o_sram_re_n,
    output logic        o_spi_clk,
    output logic        o_spi_mosi,
    output logic        o_spi_cs_n,
    input  logic        i_spi_miso,
    input  logic        i_ft_cs,      // Low while the USB bridge programs flash
    input  logic        i_ft_sck,
    input  logic        i_ft_mosi,
    output logic        o_ft_miso
);
    import mtl_adapter_pkg::*;

    logic        e_long;
    logic        e_short;
    mem_region_t region;
    logic        sram_sel;
    logic        rom_sel;
    logic        prog_mode;
    logic        rdr_spi_clk;
    logic        rdr_spi_mosi;
    logic        rdr_spi_cs_n;
    logic [7:0]  rom_data;

    assign prog_mode = !i_ft_cs;

    e_clk_delay #(
        .E_LONG_DELAY  (E_LONG_DELAY),
        .E_SHORT_DELAY (E_SHORT_DELAY)
    ) u_e_clk_delay (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_e       (i_e),
        .o_e_long  (e_long),
        .o_e_short (e_short)
    );

    address_decoder u_address_decoder (
        .i_addr        (i_addr),
        .i_prog_mode   (prog_mode),
        .o_region      (region),
        .o_sram_sel    (sram_sel),
        .o_rom_sel     (rom_sel),
        .o_exp_mem_sel (),             // Expansion areas have no device on this board
        .o_exp_io_sel  ()
    );

    sram_strobe_ctrl u_sram_strobe_ctrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_sram_sel  (sram_sel),
        .i_rw        (i_rw),
        .i_e_long    (e_long),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_ce2  (o_sram_ce2),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_re_n (o_sram_re_n)
    );

    spi_flash_reader #(
        .SPI_CLK_DIV (SPI_CLK_DIV),
        .FLASH_BASE  (FLASH_BASE)
    ) u_spi_flash_reader (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rom_sel  (rom_sel),
        .i_rw       (i_rw),
        .i_e_long   (e_long),
        .i_addr     (i_addr[11:0]),
        .i_spi_miso (i_spi_miso),
        .o_spi_clk  (rdr_spi_clk),
        .o_spi_mosi (rdr_spi_mosi),
        .o_spi_cs_n (rdr_spi_cs_n),
        .o_mrdy     (o_mrdy),
        .o_rom_data (rom_data)
    );

    assign o_data    = rom_data;                     // ROM is the only internal read source
    assign o_data_oe = rom_sel && i_rw && o_mrdy;    // Drive once the byte is in

    // Buffer opens early for SRAM and ROM writes, and for ROM reads once data is ready
    assign o_dben_n = !((sram_sel && e_short) ||
                        (rom_sel && ((i_rw && o_mrdy) || (!i_rw && e_short))));

    assign o_spi_clk  = i_ft_cs ? rdr_spi_clk  : i_ft_sck;    // Bridge owns the pins when low
    assign o_spi_mosi = i_ft_cs ? rdr_spi_mosi : i_ft_mosi;
    assign o_spi_cs_n = i_ft_cs ? rdr_spi_cs_n : i_ft_cs;
    assign o_ft_miso  = i_ft_cs ? 1'b0 : i_spi_miso;          // Bridge sees flash only when it owns it

    // A CPU stall only ever comes from a ROM access, never from another region
    stall_only_rom: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_mrdy |-> (region == REGION_ROM));

endmodule

// ==== source/spi_flash_reader.sv ====
module spi_flash_reader #(
    parameter int                                   SPI_CLK_DIV = 2,
    parameter logic [mtl_adapter_pkg::FLASH_ADDR_W-1:0] FLASH_BASE  = '0
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_rom_sel,
    input  logic        i_rw,
    input  logic        i_e_long,
    input  logic [11:0] i_addr,        // Offset inside the ROM window
    input  logic        i_spi_miso,
    output logic        o_spi_clk,
    output logic        o_spi_mosi,
    output logic        o_spi_cs_n,
    output logic        o_mrdy,        // Low stretches the CPU clock
    output logic [7:0]  o_rom_data
);
    import mtl_adapter_pkg::*;

    localparam int TX_W  = 8 + FLASH_ADDR_W;  // Opcode then address
    localparam int CNT_W = $clog2(TX_W);
    localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,      // Command and address out
        S_RECEIVE,    // Data byte in
        S_DONE        // Byte held until E drops
    } state_t;

    state_t                  state;
    logic                    e_long_q;     // For E rise detect
    logic                    start;
    logic                    busy;
    logic                    tick;         // Half SPI period elapsed
    logic [DIV_W-1:0]        div_cnt;
    logic [CNT_W-1:0]        bit_cnt;
    logic [TX_W-1:0]         tx_shift;
    logic [7:0]              rx_shift;
    logic [FLASH_ADDR_W-1:0] flash_addr;

    assign flash_addr = FLASH_BASE + {{(FLASH_ADDR_W-12){1'b0}}, i_addr};
    assign start      = i_e_long && !e_long_q && i_rom_sel && i_rw && (state == S_IDLE);
    assign busy       = (state == S_SHIFT) || (state == S_RECEIVE);
    assign tick       = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));
    assign o_mrdy     = !(start || busy);       // Drops in the start cycle itself
    assign o_spi_mosi = tx_shift[TX_W-1];       // MSB first

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            e_long_q   <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            o_spi_clk  <= 1'b0;                 // Mode 0 idles low
            o_spi_cs_n <= 1'b1;
        end else begin
            e_long_q <= i_e_long;
            div_cnt  <= (busy && !tick) ? div_cnt + 1'b1 : '0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state      <= S_SHIFT;
                        o_spi_cs_n <= 1'b0;
                        bit_cnt    <= '0;
                    end
                end
                S_SHIFT: begin
                    if (tick) begin
                        if (!o_spi_clk) begin
                            o_spi_clk <= 1'b1;  // Flash samples MOSI here
                        end else begin
                            o_spi_clk <= 1'b0;
                            bit_cnt   <= bit_cnt + 1'b1;
                            if (bit_cnt == CNT_W'(TX_W - 1)) begin
                                state   <= S_RECEIVE;  // Flash starts driving on this fall
                                bit_cnt <= '0;
                            end
                        end
                    end
                end
                S_RECEIVE: begin
                    if (tick) begin
                        if (!o_spi_clk) begin
                            o_spi_clk <= 1'b1;
                        end else begin
                            o_spi_clk <= 1'b0;
                            bit_cnt   <= bit_cnt + 1'b1;
                            if (bit_cnt == CNT_W'(7)) begin
                                state      <= S_DONE;
                                o_spi_cs_n <= 1'b1;    // Ends the READ, clock already low
                            end
                        end
                    end
                end
                S_DONE: begin
                    if (!i_e_long) begin
                        state <= S_IDLE;        // One read per E window
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start) begin
            tx_shift <= {FLASH_READ_CMD, flash_addr};
        end else if ((state == S_SHIFT) && tick && o_spi_clk) begin
            tx_shift <= {tx_shift[TX_W-2:0], 1'b0};   // Next bit after falling edge
        end
        if ((state == S_RECEIVE) && tick && !o_spi_clk) begin
            rx_shift <= {rx_shift[6:0], i_spi_miso};  // Sample with the rising edge
        end
        if ((state == S_RECEIVE) && tick && o_spi_clk && (bit_cnt == CNT_W'(7))) begin
            o_rom_data <= rx_shift;
        end
    end

    // The CPU holds E high for as long as MRDY stretches the cycle
    stall_holds_e: assert property (@(posedge i_clk) disable iff (i_rst)
        !o_mrdy |-> i_e_long);

endmodule

// ==== source/sram_strobe_ctrl.sv ====
module sram_strobe_ctrl (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_sram_sel,    // Address decodes to SRAM
    input  logic i_rw,          // 1 read, 0 write
    input  logic i_e_long,      // Delayed E window
    output logic o_sram_ce_n,
    output logic o_sram_ce2,
    output logic o_sram_we_n,
    output logic o_sram_re_n
);

    logic access;  // SRAM cycle inside the delayed E window

    assign access = i_sram_sel && i_e_long;

    // Registered so the enables stay clean while the address bus settles
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_sram_ce_n <= 1'b1;
            o_sram_ce2  <= 1'b0;
            o_sram_we_n <= 1'b1;
            o_sram_re_n <= 1'b1;
        end else begin
            o_sram_ce_n <= !access;
            o_sram_ce2  <= access;                // Second enable tracks the first
            o_sram_we_n <= !(access && !i_rw);    // Write pulse
            o_sram_re_n <= !(access && i_rw);     // Output enable for reads
        end
    end

    // The CPU keeps R/W steady for a whole enabled SRAM window
    rw_steady: assert property (@(posedge i_clk) disable iff (i_rst)
        (!o_sram_ce_n && $past(!o_sram_ce_n)) |-> $stable(o_sram_we_n));

endmodule

// ==== sources.f ====
source/mtl_adapter_pkg.sv
source/e_clk_delay.sv
source/address_decoder.sv
source/sram_strobe_ctrl.sv
source/spi_flash_reader.sv
source/mtl_memory_adapter.sv
verification/spi_flash_model.sv
verification/tb_mtl_memory_adapter.sv

// ==== verification/bus_cycle_vectors.txt ====
// prog rw addr wdata region rom_byte, all hex
// region 0 none, 1 sram, 2 exp mem, 3 exp io, 4 rom; a prog of f ends the list
0 0 0000 11 1 00
0 1 0000 00 1 00
0 0 0ABC 3C 1 00
0 1 0FFF 00 1 00
0 1 1000 00 2 00
0 0 7FFF 44 2 00
0 1 4321 00 2 00
0 1 A000 00 3 00
0 0 BFFF 5E 3 00
0 1 8000 00 0 00
0 1 C000 00 0 00
0 1 F000 00 4 5A
0 1 F123 00 4 78
0 0 F123 99 4 00
0 1 FFFE 00 4 AB
0 1 FFFF 00 4 AA
1 1 F5A5 00 4 00
1 0 0100 21 1 00
0 1 F5A5 00 4 FA
0 1 F800 00 4 52
0 1 0800 00 1 00
f 0 0000 00 0 00

// ==== verification/spi_flash_model.sv ====
module spi_flash_model (
    input  logic i_sck,
    input  logic i_mosi,
    input  logic i_cs_n,
    output logic o_miso
);

    int          bit_cnt;    // Rising SCK edges since CS fell
    int          txn_count;  // Clocked transactions seen, read by the testbench
    logic [31:0] cmd_addr;   // Opcode then 24 bit address
    logic [7:0]  data_byte;

    initial begin
        bit_cnt   = 0;
        txn_count = 0;
        cmd_addr  = '0;
        data_byte = '0;
        o_miso    = 1'b0;
    end

    // Mode 0 flash samples MOSI on the rising edge
    always @(posedge i_sck or posedge i_cs_n) begin
        if (i_cs_n) begin
            bit_cnt = 0;                                 // Deselect ends the command
        end else begin
            if (bit_cnt == 0) begin
                txn_count = txn_count + 1;
            end
            if (bit_cnt < 32) begin
                cmd_addr = {cmd_addr[30:0], i_mosi};
            end
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 32) begin
                if (cmd_addr[31:24] == 8'h03) begin
                    data_byte = cmd_addr[7:0] ^ cmd_addr[15:8] ^ 8'h5A;  // Content rule
                end else begin
                    data_byte = 8'hFF;                   // Unknown opcode reads erased
                end
            end
        end
    end

    // Data goes out on the falling edge, MSB first
    always @(negedge i_sck) begin
        if (!i_cs_n && (bit_cnt >= 32) && (bit_cnt < 40)) begin
            o_miso = data_byte[39 - bit_cnt];
        end
    end

endmodule

// ==== verification/tb_mtl_memory_adapter.sv ====
module tb_mtl_memory_adapter;
    import mtl_adapter_pkg::*;

    localparam int          E_HIGH      = 8;     // Cycles E is held before any stall
    localparam int          MAX_VEC     = 32;
    localparam int          STALL_LIMIT = 1000;  // Cycles allowed for one flash read
    localparam logic [23:0] FLASH_BASE  = 24'h010000;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        rw;
    logic        e;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        data_oe, mrdy, dben_n;
    logic        sram_ce_n, sram_ce2, sram_we_n, sram_re_n;
    logic        spi_clk, spi_mosi, spi_cs_n, spi_miso;
    logic        ft_cs, ft_sck, ft_mosi, ft_miso;

    logic [15:0] vec_mem [0:6*MAX_VEC-1];  // Six columns per bus cycle
    logic [7:0]  lfsr;
    int          errors;
    int          checks;
    bit          aborted;
    bit          saw_ce, saw_dben, saw_stall;
    bit          cur_prog, cur_rw, cur_rom_read;
    mem_region_t cur_region;

    mtl_memory_adapter #(.FLASH_BASE(FLASH_BASE)) u_mtl_memory_adapter (
        .i_clk (clk), .i_rst (rst), .i_addr (addr), .i_rw (rw), .i_e (e),
        .i_data (wdata), .o_data (rdata), .o_data_oe (data_oe), .o_mrdy (mrdy),
        .o_dben_n (dben_n), .o_sram_ce_n (sram_ce_n), .o_sram_ce2 (sram_ce2),
        .o_sram_we_n (sram_we_n), .o_sram_re_n (sram_re_n), .o_spi_clk (spi_clk),
        .o_spi_mosi (spi_mosi), .o_spi_cs_n (spi_cs_n), .i_spi_miso (spi_miso),
        .i_ft_cs (ft_cs), .i_ft_sck (ft_sck), .i_ft_mosi (ft_mosi), .o_ft_miso (ft_miso)
    );

    spi_flash_model u_spi_flash (
        .i_sck (spi_clk), .i_mosi (spi_mosi), .i_cs_n (spi_cs_n), .o_miso (spi_miso)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("error %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Expected ROM byte from the flash content rule
    function automatic logic [7:0] flash_byte(input logic [15:0] a);
        logic [23:0] fa;
        fa = FLASH_BASE + {12'h000, a[11:0]};
        return fa[7:0] ^ fa[15:8] ^ 8'h5A;
    endfunction

    // Fibonacci LFSR x^8+x^6+x^5+x^4+1, one step per bit
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic sample_outputs();
        if (cur_region == REGION_SRAM) begin
            if (!sram_ce_n) begin
                saw_ce = 1'b1;
                check_value("o_sram_ce2", sram_ce2, 1);
                check_value("o_sram_we_n", sram_we_n, cur_rw);   // Write strobe on writes only
                check_value("o_sram_re_n", sram_re_n, !cur_rw);
            end else begin
                check_value("o_sram_we_n", sram_we_n, 1);
                check_value("o_sram_re_n", sram_re_n, 1);
            end
            if (!dben_n) saw_dben = 1'b1;
        end else begin
            check_value("o_sram_ce_n", sram_ce_n, 1);
            check_value("o_sram_ce2", sram_ce2, 0);
            check_value("o_sram_we_n", sram_we_n, 1);
            check_value("o_sram_re_n", sram_re_n, 1);
            if (cur_region != REGION_ROM) check_value("o_dben_n", dben_n, 1);
        end
        if (!mrdy) saw_stall = 1'b1;
        if (!cur_rom_read) begin
            check_value("o_mrdy", mrdy, 1);
            check_value("o_data_oe", data_oe, 0);
        end
        if (cur_prog) begin
            check_value("o_spi_clk", spi_clk, ft_sck);  // Bridge owns the flash pins
            check_value("o_spi_mosi", spi_mosi, ft_mosi);
            check_value("o_spi_cs_n", spi_cs_n, 0);
            check_value("o_ft_miso", ft_miso, spi_miso);
        end
    endtask

    // USB bridge READ of one flash byte, one SCK half period per clock
    task automatic bridge_read(input logic [15:0] a);
        logic [31:0] tx;
        logic [7:0]  rx;
        tx = {FLASH_READ_CMD, FLASH_BASE + {12'h000, a[11:0]}};
        rx = '0;
        for (int b = 0; b < 40; b++) begin
            ft_mosi = (b < 32) ? tx[31 - b] : 1'b0;
            @(negedge clk);
            sample_outputs();
            ft_sck = 1'b1;                     // Flash takes MOSI on this rise
            @(negedge clk);
            sample_outputs();
            if (b >= 32) rx = {rx[6:0], ft_miso};
            ft_sck = 1'b0;
        end
        check_value("o_ft_miso_byte", rx, flash_byte(a));
    endtask

    // One CPU bus cycle, entered and left on a falling clock edge
    task automatic run_cycle(input logic prog, input logic r, input logic [15:0] a,
                             input logic [7:0] d, input logic [2:0] region,
                             input logic [7:0] rom_exp);
        int wait_cnt;
        int txn_before;
        int gap;
        cur_prog     = prog;
        cur_rw       = r;
        cur_region   = mem_region_t'(region);
        cur_rom_read = (cur_region == REGION_ROM) && r && !prog;
        saw_ce       = 1'b0;
        saw_dben     = 1'b0;
        saw_stall    = 1'b0;
        txn_before   = u_spi_flash.txn_count;
        addr  = a;
        rw    = r;
        wdata = d;
        ft_cs = !prog;
        e     = 1'b1;
        for (int cyc = 0; cyc < E_HIGH; cyc++) begin
            @(negedge clk);
            sample_outputs();
        end
        if (prog) begin
            bridge_read(a);               // Bridge reads flash while the CPU is locked out
        end
        wait_cnt = 0;
        while (!mrdy && !aborted) begin   // CPU keeps E high during the stall
            @(negedge clk);
            wait_cnt = wait_cnt + 1;
            if (wait_cnt > STALL_LIMIT) begin
                $display("Timeout: MRDY stayed low on the ROM read of address %h", a);
                errors  = errors + 1;
                aborted = 1'b1;
            end
        end
        if (cur_rom_read && !aborted) begin
            check_value("o_mrdy_stalled", saw_stall, 1);
            check_value("o_data_oe", data_oe, 1);
            check_value("o_dben_n", dben_n, 0);
            check_value("o_data", rdata, flash_byte(a));
            check_value("o_data_vector", rdata, rom_exp);
            check_value("flash_txn_count", u_spi_flash.txn_count - txn_before, 1);
        end else if (!prog) begin
            check_value("flash_txn_count", u_spi_flash.txn_count - txn_before, 0);
        end
        if (cur_region == REGION_SRAM) begin
            check_value("o_sram_ce_n_active", saw_ce, 1);
            check_value("o_dben_n_active", saw_dben, 1);
        end
        e     = 1'b0;
        ft_cs = 1'b1;
        gap   = 7 + rand_bits(3);   // Lets the delayed E fall before the next cycle
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int idx;
        rst     = 1'b1;
        e       = 1'b0;
        rw      = 1'b1;
        addr    = '0;
        wdata   = '0;
        ft_cs   = 1'b1;
        ft_sck  = 1'b0;
        ft_mosi = 1'b0;
        lfsr    = 8'd61;
        errors  = 0;
        checks  = 0;
        aborted = 1'b0;
        $readmemh("verification/bus_cycle_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_mrdy", mrdy, 1);          // Idle state before any E pulse
        check_value("o_dben_n", dben_n, 1);
        check_value("o_data_oe", data_oe, 0);
        check_value("o_sram_ce_n", sram_ce_n, 1);
        check_value("o_sram_ce2", sram_ce2, 0);
        check_value("o_sram_we_n", sram_we_n, 1);
        check_value("o_sram_re_n", sram_re_n, 1);
        idx = 0;
        while ((idx < MAX_VEC) && (vec_mem[6*idx] != 16'h000F) && !aborted) begin
            run_cycle(vec_mem[6*idx][0], vec_mem[6*idx+1][0], vec_mem[6*idx+2],
                      vec_mem[6*idx+3][7:0], vec_mem[6*idx+4][2:0], vec_mem[6*idx+5][7:0]);
            idx = idx + 1;
        end
        if (idx == 0) begin
            $display("No bus cycles were read from the vector file");
            errors = errors + 1;
        end
        $display("Bus cycles: %0d  checks: %0d  errors: %0d", idx, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
